// File: hdl/stepper_config.svh
`ifndef STEPPER_CONFIG_SVH
`define STEPPER_CONFIG_SVH

// Move ring buffer
`define MOVE_BUFFER_BITS 2
`define MOVE_BUFFER_SIZE 4

// Command header codes in the top byte of a first word
`define CMD_COORDINATED_STEP 8'h01
`define CMD_MOTOR_ENABLE     8'h0a
`define CMD_CLK_DIVISOR      8'h14
`define CMD_MOTORCONFIG      8'h1e
`define CMD_CHARGEPUMP       8'h32
`define CMD_BRIDGEINVERT     8'h3c
`define CMD_API_VERSION      8'hfe

// Reported by the version command
`define VERSION_MAJOR 8'd0
`define VERSION_MINOR 8'd2
`define VERSION_PATCH 8'd1

// Accumulator bit that marks one step when it changes
`define DDA_STEP_BIT 32

// Configuration register reset values
`define RESET_MICROSTEPS       3'd2
`define RESET_CURRENT          8'd140
`define RESET_CHARGEPUMP       8'd91
`define RESET_CLOCK_DIVISOR    8'd40

`endif

// File: hdl/stepper_pkg.sv
package stepper_pkg;

  // One 64-bit SPI word, MSB first on the wire
  typedef union packed {
    // First word of a message
    struct packed {
      // Command code
      logic [7:0]  header;
      // Single-word command arguments live in the low bits
      logic [55:0] payload;
    } hdr;

    // Later words of a message carry one full move parameter
    logic [63:0] data;
  } spi_word_u;

endpackage

// File: hdl/move_if.sv
`include "stepper_config.svh"

interface move_if;

  // Slot storage written by the decoder
  logic [63:0]        move_duration      [`MOVE_BUFFER_SIZE];
  logic signed [63:0] increment          [`MOVE_BUFFER_SIZE];
  logic signed [63:0] incrementincrement [`MOVE_BUFFER_SIZE];
  logic [`MOVE_BUFFER_SIZE-1:0] dir;

  // Slot is full while these two bits differ
  logic [`MOVE_BUFFER_SIZE-1:0] stepready;
  logic [`MOVE_BUFFER_SIZE-1:0] stepfinished;

  // Slot under execution
  logic [`MOVE_BUFFER_BITS-1:0] moveind;

  modport decoder (
    output move_duration, increment, incrementincrement, dir, stepready,
    input  stepfinished
  );

  modport executor (
    input  move_duration, increment, incrementincrement, dir, stepready,
    output stepfinished, moveind
  );

endinterface

// File: hdl/spi_word.sv
module spi_word
  import stepper_pkg::*;
(
  input  logic      CLK,
  input  logic      resetn,
  input  logic      sck,
  input  logic      cs,
  input  logic      copi,
  output logic      cipo,
  input  spi_word_u send_data,
  output logic      word_received,
  output spi_word_u word_data
);

  // Two sync stages, third bit keeps the previous value for edges
  logic [2:0] sck_q;
  logic [2:0] cs_q;
  logic [1:0] copi_q;

  logic sck_rise;
  logic sck_fall;
  logic cs_active;
  logic cs_start;

  // Bits taken so far in the current word
  logic [5:0]  bit_count;
  logic [62:0] rx_shift;
  logic [63:0] tx_shift;

  // Delays the reply reload until the decoder has updated send_data
  logic [1:0] reload_q;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_q  <= '0;
      cs_q   <= '1;
      copi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_q   <= {cs_q[1:0], cs};
      copi_q <= {copi_q[0], copi};
    end
  end

  assign sck_rise  = sck_q[1] & ~sck_q[2];
  assign sck_fall  = ~sck_q[1] & sck_q[2];
  assign cs_active = ~cs_q[1];
  assign cs_start  = ~cs_q[1] & cs_q[2];

  // Bit counter and word strobe
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_count     <= '0;
      word_received <= 1'b0;
      reload_q      <= '0;
    end else begin
      word_received <= 1'b0;
      reload_q      <= {reload_q[0], word_received};
      if (!cs_active) begin
        // Deselect aborts any partial word
        bit_count <= '0;
      end else if (sck_rise) begin
        bit_count <= bit_count + 6'd1;
        if (bit_count == 6'd63) begin
          word_received <= 1'b1;
        end
      end
    end
  end

  // Receive shifter, MSB first
  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[61:0], copi_q[1]};
      if (bit_count == 6'd63) begin
        word_data <= {rx_shift, copi_q[1]};
      end
    end
  end

  // Reply shifter
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      tx_shift <= '0;
    end else if (cs_start || reload_q[1]) begin
      // Next reply sits on cipo before the first rising edge
      tx_shift <= send_data;
    end else if (cs_active && sck_fall && bit_count != 6'd0) begin
      // Falling edge after the last bit leaves the reply in place
      tx_shift <= {tx_shift[62:0], 1'b0};
    end
  end

  assign cipo = tx_shift[63];

endmodule

// File: hdl/spi_state_machine.sv
`include "stepper_config.svh"

module spi_state_machine
  import stepper_pkg::*;
(
  input  logic        CLK,
  input  logic        resetn,
  input  logic        word_received,
  input  spi_word_u   word_data,
  output spi_word_u   send_data,
  input  logic [63:0] encoder_count,
  output logic        enable,
  output logic [2:0]  microsteps,
  output logic [7:0]  current,
  output logic [7:0]  config_chargepump_period,
  output logic        config_invert_highside,
  output logic        config_invert_lowside,
  output logic [7:0]  clock_divisor,
  output logic        buffer_dtr,
  move_if.decoder     mv
);

  // Registered copy of the received word
  logic      word_valid;
  spi_word_u word_q;

  // Message sequencing
  logic [7:0] message_header;
  logic [2:0] word_count;
  logic       awaiting_more_words;

  // Move buffer write side
  logic [`MOVE_BUFFER_BITS-1:0] writemoveind;
  logic [63:0] encoder_store;
  logic        move_hdr;
  logic        move_data;
  logic        move_commit;

  // Only these two commands span more than one word
  assign awaiting_more_words = (message_header == `CMD_COORDINATED_STEP) ||
                               (message_header == `CMD_API_VERSION);

  assign move_hdr = word_valid && !awaiting_more_words &&
                    (word_q.hdr.header == `CMD_COORDINATED_STEP);
  assign move_data   = word_valid && (message_header == `CMD_COORDINATED_STEP);
  assign move_commit = move_data && (word_count == 3'd3);

  // At least one slot with matching toggles
  assign buffer_dtr = |(mv.stepready ~^ mv.stepfinished);

  // Word capture and slot contents
  always_ff @(posedge CLK) begin
    if (word_received) begin
      word_q <= word_data;
    end
    if (move_hdr) begin
      mv.dir[writemoveind] <= word_q.hdr.payload[0];
      // Position snapshot at the start of the move message
      encoder_store <= encoder_count;
    end
    if (move_data) begin
      case (word_count)
        3'd1: mv.move_duration[writemoveind] <= word_q.data;
        3'd2: mv.increment[writemoveind] <= word_q.data;
        3'd3: mv.incrementincrement[writemoveind] <= word_q.data;
        default: ;
      endcase
    end
  end

  // Command decode
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      word_valid               <= 1'b0;
      message_header           <= 8'd0;
      word_count               <= 3'd0;
      writemoveind             <= '0;
      mv.stepready             <= '0;
      send_data                <= '0;
      enable                   <= 1'b0;
      microsteps               <= `RESET_MICROSTEPS;
      current                  <= `RESET_CURRENT;
      config_chargepump_period <= `RESET_CHARGEPUMP;
      config_invert_highside   <= 1'b0;
      config_invert_lowside    <= 1'b0;
      clock_divisor            <= `RESET_CLOCK_DIVISOR;
    end else begin
      word_valid <= word_received;
      if (word_valid) begin
        // Zero reply unless a command prepares one
        send_data <= '0;
        if (!awaiting_more_words) begin
          // Header word
          message_header <= word_q.hdr.header;
          word_count     <= 3'd1;
          case (word_q.hdr.header)
            `CMD_MOTOR_ENABLE: enable <= word_q.hdr.payload[0];
            `CMD_CLK_DIVISOR: clock_divisor <= word_q.hdr.payload[7:0];
            `CMD_MOTORCONFIG: begin
              current    <= word_q.hdr.payload[15:8];
              microsteps <= word_q.hdr.payload[2:0];
            end
            `CMD_CHARGEPUMP: config_chargepump_period <= word_q.hdr.payload[7:0];
            `CMD_BRIDGEINVERT: begin
              config_invert_highside <= word_q.hdr.payload[1];
              config_invert_lowside  <= word_q.hdr.payload[0];
            end
            `CMD_API_VERSION: begin
              send_data.data <= {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};
            end
            // Move header and unknown codes touch no register here
            default: ;
          endcase
        end else if (message_header == `CMD_COORDINATED_STEP) begin
          word_count <= word_count + 3'd1;
          if (word_count == 3'd2) begin
            // Snapshot goes out during the last move word
            send_data.data <= encoder_store;
          end
          if (move_commit) begin
            word_count     <= 3'd0;
            message_header <= 8'd0;
            // Hand the slot to the executor
            mv.stepready[writemoveind] <= ~mv.stepready[writemoveind];
            // Two bit index wraps with the ring
            writemoveind <= writemoveind + 1'b1;
          end
        end else begin
          // Filler word after the version header
          word_count     <= 3'd0;
          message_header <= 8'd0;
        end
      end
    end
  end

  // Host waits on buffer_dtr so a committed slot was released by the executor
  a_no_overwrite: assert property (@(posedge CLK) disable iff (!resetn)
    move_commit |-> (mv.stepready[writemoveind] == mv.stepfinished[writemoveind]))
    else $error("move written into a full slot");

  // Longest message is a header and three data words
  a_word_count: assert property (@(posedge CLK) disable iff (!resetn)
    word_valid |=> (word_count <= 3'd3))
    else $error("message word count past three");

endmodule

// File: hdl/dda_timer.sv
`include "stepper_config.svh"

module dda_timer
  import stepper_pkg::*;
(
  input  logic       CLK,
  input  logic       resetn,
  input  logic [7:0] clock_divisor,
  input  logic       halt,
  move_if.executor   mv,
  output logic       step,
  output logic       dir,
  output logic       move_done
);

  logic       running;
  logic [7:0] div_count;
  logic       tick;
  logic       slot_full;
  logic       start;
  logic       finish;

  // Move state
  logic [63:0]        remaining;
  logic signed [63:0] velocity;
  logic signed [63:0] accum;
  logic signed [63:0] accum_next;

  assign slot_full = mv.stepready[mv.moveind] != mv.stepfinished[mv.moveind];
  assign start     = !running && slot_full;
  assign finish    = running && (remaining == 64'd0);

  // One tick per clock_divisor plus one cycles, frozen by halt
  assign tick = running && !halt && (remaining != 64'd0) &&
                (div_count == clock_divisor);

  // Accumulator adds the velocity from before this tick
  assign accum_next = accum + velocity;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      running         <= 1'b0;
      div_count       <= 8'd0;
      step            <= 1'b0;
      dir             <= 1'b0;
      move_done       <= 1'b0;
      mv.stepfinished <= '0;
      mv.moveind      <= '0;
    end else begin
      step      <= 1'b0;
      move_done <= 1'b0;
      if (start) begin
        running   <= 1'b1;
        div_count <= 8'd0;
        // Direction held for the whole move
        dir <= mv.dir[mv.moveind];
      end else if (finish) begin
        running   <= 1'b0;
        move_done <= 1'b1;
        // Release the slot back to the decoder
        mv.stepfinished[mv.moveind] <= ~mv.stepfinished[mv.moveind];
        if (mv.moveind == `MOVE_BUFFER_BITS'(`MOVE_BUFFER_SIZE - 1)) begin
          mv.moveind <= '0;
        end else begin
          mv.moveind <= mv.moveind + 1'b1;
        end
      end else if (running && !halt) begin
        if (tick) begin
          div_count <= 8'd0;
          // Any change of the step bit is one step
          step <= accum_next[`DDA_STEP_BIT] != accum[`DDA_STEP_BIT];
        end else begin
          div_count <= div_count + 8'd1;
        end
      end
    end
  end

  // DDA datapath
  always_ff @(posedge CLK) begin
    if (start) begin
      remaining <= mv.move_duration[mv.moveind];
      velocity  <= mv.increment[mv.moveind];
      accum     <= '0;
    end else if (tick) begin
      remaining <= remaining - 64'd1;
      // Slot stays full while running so its parameters hold
      velocity  <= velocity + mv.incrementincrement[mv.moveind];
      accum     <= accum_next;
    end
  end

  // Paused moves emit nothing
  a_no_step_in_halt: assert property (@(posedge CLK) disable iff (!resetn)
    $rose(step) |-> !$past(halt))
    else $error("step while halted");

  // Executor only releases slots the decoder has filled
  a_finish_full: assert property (@(posedge CLK) disable iff (!resetn)
    finish |-> slot_full)
    else $error("finished an empty slot");

endmodule

// File: hdl/stepper_top.sv
module stepper_top
  import stepper_pkg::*;
(
  input  logic        CLK,
  input  logic        resetn,
  input  logic        sck,
  input  logic        cs,
  input  logic        copi,
  output logic        cipo,
  input  logic [63:0] encoder_count,
  input  logic        halt,
  output logic        step,
  output logic        dir,
  output logic        enable,
  output logic [2:0]  microsteps,
  output logic [7:0]  current,
  output logic [7:0]  config_chargepump_period,
  output logic        config_invert_highside,
  output logic        config_invert_lowside,
  output logic        buffer_dtr,
  output logic        move_done
);

  // SPI word link
  spi_word_u  send_data;
  spi_word_u  word_data;
  logic       word_received;

  // Tick rate from decoder to executor
  logic [7:0] clock_divisor;

  // Move ring buffer shared by decoder and executor
  move_if mv ();

  spi_word u_spi_word (
    .CLK           (CLK),
    .resetn        (resetn),
    .sck           (sck),
    .cs            (cs),
    .copi          (copi),
    .cipo          (cipo),
    .send_data     (send_data),
    .word_received (word_received),
    .word_data     (word_data)
  );

  spi_state_machine u_decode (
    .CLK                      (CLK),
    .resetn                   (resetn),
    .word_received            (word_received),
    .word_data                (word_data),
    .send_data                (send_data),
    .encoder_count            (encoder_count),
    .enable                   (enable),
    .microsteps               (microsteps),
    .current                  (current),
    .config_chargepump_period (config_chargepump_period),
    .config_invert_highside   (config_invert_highside),
    .config_invert_lowside    (config_invert_lowside),
    .clock_divisor            (clock_divisor),
    .buffer_dtr               (buffer_dtr),
    .mv                       (mv.decoder)
  );

  dda_timer u_dda (
    .CLK           (CLK),
    .resetn        (resetn),
    .clock_divisor (clock_divisor),
    .halt          (halt),
    .mv            (mv.executor),
    .step          (step),
    .dir           (dir),
    .move_done     (move_done)
  );

endmodule

// File: testbench/tb_stepper.sv
`include "stepper_config.svh"

module tb_stepper
  import stepper_pkg::*;
();

  // SPI half period and gap between words, in CLK cycles
  localparam int HALF = 4;
  localparam int GAP  = 8;

  logic        CLK;
  logic        resetn;
  logic        sck;
  logic        cs;
  logic        copi;
  logic        cipo;
  logic [63:0] encoder_count;
  logic        halt;
  logic        step;
  logic        dir;
  logic        enable;
  logic [2:0]  microsteps;
  logic [7:0]  current;
  logic [7:0]  config_chargepump_period;
  logic        config_invert_highside;
  logic        config_invert_lowside;
  logic        buffer_dtr;
  logic        move_done;

  // Expected configuration outputs
  logic       exp_enable;
  logic [2:0] exp_microsteps;
  logic [7:0] exp_current;
  logic [7:0] exp_chargepump;
  logic       exp_inv_high;
  logic       exp_inv_low;

  // Step monitor state
  logic step_q;
  logic halt_q;
  int   step_count = 0;
  int   up_count = 0;
  int   halted_steps = 0;
  int   done_count = 0;

  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  stepper_top dut0 (
    .CLK                      (CLK),
    .resetn                   (resetn),
    .sck                      (sck),
    .cs                       (cs),
    .copi                     (copi),
    .cipo                     (cipo),
    .encoder_count            (encoder_count),
    .halt                     (halt),
    .step                     (step),
    .dir                      (dir),
    .enable                   (enable),
    .microsteps               (microsteps),
    .current                  (current),
    .config_chargepump_period (config_chargepump_period),
    .config_invert_highside   (config_invert_highside),
    .config_invert_lowside    (config_invert_lowside),
    .buffer_dtr               (buffer_dtr),
    .move_done                (move_done)
  );

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  // Rising edges of step, split by direction
  always @(posedge CLK) begin
    step_q <= step;
    halt_q <= halt;
    if (step && !step_q) begin
      step_count <= step_count + 1;
      if (dir) begin
        up_count <= up_count + 1;
      end
      // Pulse caused by a tick taken while halted
      if (halt_q) begin
        halted_steps <= halted_steps + 1;
      end
    end
    if (move_done) begin
      done_count <= done_count + 1;
    end
  end

  task automatic flag_error(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_start);
    end
  endtask

  // Steps from the DDA rule, one loop pass per tick
  function automatic int predict_steps(input int dur, input longint inc, input longint ii);
    longint acc;
    longint acc_next;
    longint vel;
    int     n;
    acc = 0;
    vel = inc;
    n = 0;
    for (int t = 0; t < dur; t++) begin
      acc_next = acc + vel;
      if (acc_next[`DDA_STEP_BIT] != acc[`DDA_STEP_BIT]) begin
        n++;
      end
      acc = acc_next;
      vel = vel + ii;
    end
    return n;
  endfunction

  // One 64-bit word, mode 0, MSB first; cs must already be low
  task automatic spi_xfer(input spi_word_u tx, output spi_word_u rx);
    for (int i = 63; i >= 0; i--) begin
      copi = tx.data[i];
      repeat (HALF) @(negedge CLK);
      rx.data[i] = cipo;
      sck = 1'b1;
      repeat (HALF) @(negedge CLK);
      sck = 1'b0;
    end
    // Room for the reply reload
    repeat (GAP) @(negedge CLK);
  endtask

  task automatic frame_begin();
    cs = 1'b0;
    repeat (GAP) @(negedge CLK);
  endtask

  task automatic frame_end();
    cs = 1'b1;
    repeat (GAP) @(negedge CLK);
  endtask

  // Single-word command in its own frame
  task automatic send_command(input logic [7:0] header, input logic [55:0] payload);
    spi_word_u w;
    spi_word_u r;
    w.hdr.header  = header;
    w.hdr.payload = payload;
    frame_begin();
    spi_xfer(w, r);
    frame_end();
  endtask

  // Four-word move; snap is the reply seen during the last word
  task automatic send_move(input logic mdir, input int dur, input longint inc,
                           input longint ii, input logic [63:0] enc,
                           output logic [63:0] snap);
    spi_word_u w;
    spi_word_u r;
    encoder_count = enc;
    frame_begin();
    w.hdr.header  = `CMD_COORDINATED_STEP;
    w.hdr.payload = {55'd0, mdir};
    spi_xfer(w, r);
    // Later position must not leak into the snapshot
    encoder_count = ~enc;
    w.data = 64'(dur);
    spi_xfer(w, r);
    w.data = inc;
    spi_xfer(w, r);
    w.data = ii;
    spi_xfer(w, r);
    snap = r.data;
    frame_end();
  endtask

  task automatic wait_done(input int target, input int limit);
    int n;
    n = 0;
    while (done_count < target && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (done_count < target) begin
      errors++;
      $display("timeout: move_done number %0d never came within %0d cycles", target, limit);
    end
  endtask

  task automatic wait_steps(input int target, input int limit);
    int n;
    n = 0;
    while (step_count < target && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (step_count < target) begin
      errors++;
      $display("timeout: step count stuck below %0d after %0d cycles", target, limit);
    end
  endtask

  task automatic wait_dtr(input int limit);
    int n;
    n = 0;
    while (!buffer_dtr && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (!buffer_dtr) begin
      errors++;
      $display("timeout: buffer_dtr stayed low for %0d cycles", limit);
    end
  endtask

  task automatic check_outputs(input string where);
    if (enable !== exp_enable)
      flag_error($sformatf("%s: enable %b, expected %b", where, enable, exp_enable));
    if (microsteps !== exp_microsteps)
      flag_error($sformatf("%s: microsteps %0d, expected %0d", where, microsteps,
                           exp_microsteps));
    if (current !== exp_current)
      flag_error($sformatf("%s: current %0d, expected %0d", where, current, exp_current));
    if (config_chargepump_period !== exp_chargepump)
      flag_error($sformatf("%s: chargepump %0d, expected %0d", where,
                           config_chargepump_period, exp_chargepump));
    if (config_invert_highside !== exp_inv_high || config_invert_lowside !== exp_inv_low)
      flag_error($sformatf("%s: invert bits %b%b, expected %b%b", where,
                           config_invert_highside, config_invert_lowside,
                           exp_inv_high, exp_inv_low));
  endtask

  task automatic test_reset_version();
    spi_word_u w;
    spi_word_u r;
    int        e0;
    e0 = errors;
    check_outputs("reset");
    if (step !== 1'b0 || move_done !== 1'b0 || cipo !== 1'b0)
      flag_error("step, move_done or cipo not low after reset");
    if (buffer_dtr !== 1'b1)
      flag_error("buffer_dtr not high after reset");
    frame_begin();
    w.hdr.header  = `CMD_API_VERSION;
    w.hdr.payload = '0;
    spi_xfer(w, r);
    // Filler word carries the version reply back
    w.data = {$urandom, $urandom};
    spi_xfer(w, r);
    frame_end();
    if (r.data !== {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH})
      flag_error($sformatf("version reply %h", r.data));
    check_outputs("after version");
    finish_test("reset_version", e0);
  endtask

  task automatic test_config();
    spi_word_u w;
    spi_word_u r;
    int        e0;
    e0 = errors;
    send_command(`CMD_MOTOR_ENABLE, 56'd1);
    exp_enable = 1'b1;
    check_outputs("enable");
    send_command(`CMD_MOTORCONFIG, {40'd0, 8'd77, 5'd0, 3'd5});
    exp_current    = 8'd77;
    exp_microsteps = 3'd5;
    check_outputs("motorconfig");
    exp_chargepump = 8'($urandom);
    send_command(`CMD_CHARGEPUMP, {48'd0, exp_chargepump});
    check_outputs("chargepump");
    send_command(`CMD_BRIDGEINVERT, 56'd2);
    exp_inv_high = 1'b1;
    check_outputs("bridgeinvert");
    // Low side alone
    send_command(`CMD_BRIDGEINVERT, 56'd1);
    exp_inv_high = 1'b0;
    exp_inv_low  = 1'b1;
    check_outputs("bridgeinvert low");
    // Unknown code twice; the second reply must be empty
    frame_begin();
    w.hdr.header  = 8'h77;
    w.hdr.payload = '1;
    spi_xfer(w, r);
    spi_xfer(w, r);
    frame_end();
    if (r.data !== 64'd0)
      flag_error($sformatf("unknown header reply %h", r.data));
    check_outputs("unknown header");
    finish_test("config", e0);
  endtask

  task automatic test_single_move();
    logic [63:0] enc;
    logic [63:0] snap;
    int          s0;
    int          u0;
    int          d0;
    int          e0;
    e0 = errors;
    send_command(`CMD_CLK_DIVISOR, 56'd3);
    s0 = step_count;
    u0 = up_count;
    d0 = done_count;
    enc = {$urandom, $urandom};
    send_move(1'b1, 20, 64'sd2147483648, 64'sd0, enc, snap);
    if (snap !== enc)
      flag_error($sformatf("snapshot %h, expected %h", snap, enc));
    wait_done(d0 + 1, 5000);
    repeat (40) @(negedge CLK);
    if (step_count - s0 != 10 || predict_steps(20, 64'sd2147483648, 0) != 10)
      flag_error($sformatf("%0d steps, expected 10", step_count - s0));
    if (up_count - u0 != 10)
      flag_error($sformatf("%0d steps with dir high, expected 10", up_count - u0));
    if (done_count - d0 != 1)
      flag_error($sformatf("%0d move_done pulses, expected 1", done_count - d0));
    finish_test("single_move", e0);
  endtask

  task automatic test_negative_move();
    logic [63:0] snap;
    longint      inc;
    longint      ii;
    int          expected;
    int          s0;
    int          u0;
    int          e0;
    e0 = errors;
    inc = -64'sd1073741824;
    ii  = -64'sd16777216;
    expected = predict_steps(30, inc, ii);
    s0 = step_count;
    u0 = up_count;
    send_move(1'b0, 30, inc, ii, {$urandom, $urandom}, snap);
    wait_done(done_count + 1, 5000);
    repeat (20) @(negedge CLK);
    if (step_count - s0 != expected)
      flag_error($sformatf("%0d steps, expected %0d", step_count - s0, expected));
    if (up_count != u0 || dir !== 1'b0)
      flag_error("dir high during negative move");
    finish_test("negative_move", e0);
  endtask

  task automatic test_buffer_full();
    logic [63:0] snap;
    longint      inc;
    longint      ii;
    int          expected;
    int          s0;
    int          d0;
    int          e0;
    e0 = errors;
    expected = 0;
    s0 = step_count;
    d0 = done_count;
    for (int i = 0; i < `MOVE_BUFFER_SIZE; i++) begin
      inc = 64'sd268435456 * (i + 1);
      ii  = 64'sd65536 * i;
      expected += predict_steps(2000, inc, ii);
      wait_dtr(100);
      send_move(i[0], 2000, inc, ii, 64'd0, snap);
    end
    // First move still running, all slots taken
    if (buffer_dtr !== 1'b0)
      flag_error("buffer_dtr high with all slots full");
    wait_done(d0 + 1, 20000);
    if (buffer_dtr !== 1'b1)
      flag_error("buffer_dtr low after first move_done");
    wait_done(d0 + `MOVE_BUFFER_SIZE, 60000);
    repeat (20) @(negedge CLK);
    if (step_count - s0 != expected)
      flag_error($sformatf("%0d steps, expected %0d", step_count - s0, expected));
    finish_test("buffer_full", e0);
  endtask

  task automatic test_halt();
    logic [63:0] snap;
    int          expected;
    int          s0;
    int          h0;
    int          d0;
    int          e0;
    e0 = errors;
    expected = predict_steps(400, 64'sd1073741824, 64'sd0);
    s0 = step_count;
    h0 = halted_steps;
    d0 = done_count;
    send_move(1'b1, 400, 64'sd1073741824, 64'sd0, 64'd0, snap);
    wait_steps(s0 + 10, 5000);
    halt = 1'b1;
    repeat (300) @(negedge CLK);
    if (halted_steps != h0)
      flag_error($sformatf("%0d steps while halted", halted_steps - h0));
    if (done_count != d0)
      flag_error("move finished while halted");
    halt = 1'b0;
    wait_done(d0 + 1, 5000);
    repeat (20) @(negedge CLK);
    if (step_count - s0 != expected)
      flag_error($sformatf("%0d steps, expected %0d", step_count - s0, expected));
    finish_test("halt", e0);
  endtask

  initial begin
    void'($urandom(32'h61c89ba6));
    resetn        = 1'b0;
    sck           = 1'b0;
    cs            = 1'b1;
    copi          = 1'b0;
    encoder_count = 64'd0;
    halt          = 1'b0;
    exp_enable     = 1'b0;
    exp_microsteps = `RESET_MICROSTEPS;
    exp_current    = `RESET_CURRENT;
    exp_chargepump = `RESET_CHARGEPUMP;
    exp_inv_high   = 1'b0;
    exp_inv_low    = 1'b0;
    repeat (10) @(negedge CLK);
    resetn = 1'b1;
    repeat (2) @(negedge CLK);

    test_reset_version();
    test_config();
    test_single_move();
    test_negative_move();
    test_buffer_full();
    test_halt();

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+hdl
hdl/stepper_pkg.sv
hdl/move_if.sv
hdl/spi_word.sv
hdl/spi_state_machine.sv
hdl/dda_timer.sv
hdl/stepper_top.sv
testbench/tb_stepper.sv
